//--- cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

   // Front-end side, one 32-bit word per request.
   localparam int FE_ADDR_W = 32;
   localparam int FE_DATA_W = 32;
   localparam int FE_NBYTES = FE_DATA_W / 8;
   localparam int FE_BYTE_W = $clog2(FE_NBYTES);

   // Back-end side, one 128-bit line per write.
   localparam int BE_DATA_W = 128;
   localparam int BE_NBYTES = BE_DATA_W / 8;
   localparam int BE_BYTE_W = $clog2(BE_NBYTES);

   localparam int WORD_SEL_W = BE_BYTE_W - FE_BYTE_W; // Word lane inside a line.

   // Banks interleave on the low line address bits.
   localparam int N_BANKS = 4;
   localparam int BANK_W  = $clog2(N_BANKS);

endpackage

`default_nettype wire

//--- cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

   import cache_cfg_pkg::*;

   // Front-end write, word addressed.
   typedef struct packed {
      logic [FE_ADDR_W-FE_BYTE_W-1:0] addr;
      logic [FE_NBYTES-1:0]           wstrb;
      logic [FE_DATA_W-1:0]           wdata;
   } fe_write_t;

   // Back-end write, byte address aligned to a line.
   typedef struct packed {
      logic [FE_ADDR_W-1:0] addr;
      logic [BE_NBYTES-1:0] wstrb;
      logic [BE_DATA_W-1:0] wdata;
   } be_write_t;

endpackage

`default_nettype wire

//--- bank_write_router.sv
`timescale 1ns/1ns
`default_nettype none

module bank_write_router
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic               valid,
   input  wire fe_write_t          fe_req,
   output logic                    ready,
   output logic [N_BANKS-1:0]      ch_valid,
   output fe_write_t               ch_req,
   input  wire logic [N_BANKS-1:0] ch_ready
);

   logic              full;
   logic [BANK_W-1:0] bank_q;
   fe_write_t         req_q;
   logic              transfer;
   logic              accept;

   assign transfer = full & ch_ready[bank_q];
   assign ready    = ~full | transfer;
   assign accept   = valid & ready;

   // Only the target bank sees a valid.
   assign ch_valid = full ? (N_BANKS'(1) << bank_q) : '0;
   assign ch_req   = req_q;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         full <= 1'b0;
      end
      else if (accept)
      begin
         full <= 1'b1;
      end
      else if (transfer)
      begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         req_q  <= fe_req;
         bank_q <= fe_req.addr[WORD_SEL_W +: BANK_W]; // Lowest line address bits.
      end
   end

endmodule

`default_nettype wire

//--- write_channel_native.sv
`timescale 1ns/1ns
`default_nettype none

module write_channel_native
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire logic      valid,
   input  wire fe_write_t req,
   output logic           ready,
   output logic           mem_valid,
   output be_write_t      mem_req,
   input  wire logic      mem_ready
);

   typedef enum logic {
      IDLE  = 1'b0,
      WRITE = 1'b1
   } state_t;

   state_t                 state;
   fe_write_t              req_q;
   logic [WORD_SEL_W-1:0]  lane;
   logic [BE_DATA_W-1:0]   wide_data;
   logic [BE_NBYTES-1:0]   wide_strb;

   assign lane      = req_q.addr[WORD_SEL_W-1:0];
   assign wide_data = BE_DATA_W'(req_q.wdata);
   assign wide_strb = BE_NBYTES'(req_q.wstrb);

   // Line-aligned address, word placed at its lane.
   assign mem_req.addr  = {req_q.addr[FE_ADDR_W-FE_BYTE_W-1:WORD_SEL_W], {BE_BYTE_W{1'b0}}};
   assign mem_req.wdata = wide_data << (lane * FE_DATA_W);

   always_comb
   begin
      ready         = 1'b0;
      mem_valid     = 1'b0;
      mem_req.wstrb = '0; // No strobes outside the write state.
      case (state)
         IDLE:
         begin
            ready = 1'b1;
         end
         WRITE:
         begin
            mem_valid     = 1'b1;
            mem_req.wstrb = wide_strb << (lane * FE_NBYTES);
         end
         default:
         begin
            ready = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= IDLE;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (valid)
               begin
                  state <= WRITE;
               end
            end
            WRITE:
            begin
               if (mem_ready)
               begin
                  state <= IDLE; // Acknowledged.
               end
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (valid && ready)
      begin
         req_q <= req;
      end
   end

endmodule

`default_nettype wire

//--- be_write_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module be_write_arbiter
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic [N_BANKS-1:0] bank_valid,
   input  wire be_write_t          bank_req [N_BANKS],
   output logic [N_BANKS-1:0]      bank_ready,
   output logic                    mem_valid,
   output be_write_t               mem_req,
   input  wire logic               mem_ready
);

   logic              gnt_vld;
   logic [BANK_W-1:0] gnt_idx;
   logic [BANK_W-1:0] last_q;
   logic              next_vld;
   logic [BANK_W-1:0] next_idx;

   // Search starts one past the last channel served.
   always_comb
   begin
      logic [BANK_W-1:0] idx;
      next_vld = 1'b0;
      next_idx = last_q;
      for (int i = 1; i <= N_BANKS; i++)
      begin
         idx = last_q + BANK_W'(i);
         if (!next_vld && bank_valid[idx])
         begin
            next_vld = 1'b1;
            next_idx = idx;
         end
      end
   end

   assign mem_valid  = gnt_vld & bank_valid[gnt_idx];
   assign mem_req    = bank_req[gnt_idx];
   assign bank_ready = gnt_vld ? (N_BANKS'(mem_ready) << gnt_idx) : '0;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         gnt_vld <= 1'b0;
         gnt_idx <= '0;
         last_q  <= BANK_W'(N_BANKS - 1); // Channel 0 comes first.
      end
      else if (!gnt_vld)
      begin
         if (next_vld)
         begin
            gnt_vld <= 1'b1;
            gnt_idx <= next_idx;
         end
      end
      else if (mem_valid && mem_ready)
      begin
         gnt_vld <= 1'b0;
         last_q  <= gnt_idx;
      end
   end

endmodule

`default_nettype wire

//--- write_path_top.sv
`timescale 1ns/1ns
`default_nettype none

module write_path_top
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire logic      valid,
   input  wire fe_write_t fe_req,
   output logic           ready,
   output logic           mem_valid,
   output be_write_t      mem_req,
   input  wire logic      mem_ready
);

   logic [N_BANKS-1:0] ch_valid;
   logic [N_BANKS-1:0] ch_ready;
   fe_write_t          ch_req;
   logic [N_BANKS-1:0] bank_valid;
   logic [N_BANKS-1:0] bank_ready;
   be_write_t          bank_req [N_BANKS];

   bank_write_router bank_write_router_i (
      .clk      (clk),
      .reset    (reset),
      .valid    (valid),
      .fe_req   (fe_req),
      .ready    (ready),
      .ch_valid (ch_valid),
      .ch_req   (ch_req),
      .ch_ready (ch_ready)
   );

   for (genvar k = 0; k < N_BANKS; k++)
   begin : g_channel
      write_channel_native write_channel_native_i (
         .clk       (clk),
         .reset     (reset),
         .valid     (ch_valid[k]),
         .req       (ch_req),
         .ready     (ch_ready[k]),
         .mem_valid (bank_valid[k]),
         .mem_req   (bank_req[k]),
         .mem_ready (bank_ready[k])
      );
   end

   be_write_arbiter be_write_arbiter_i (
      .clk        (clk),
      .reset      (reset),
      .bank_valid (bank_valid),
      .bank_req   (bank_req),
      .bank_ready (bank_ready),
      .mem_valid  (mem_valid),
      .mem_req    (mem_req),
      .mem_ready  (mem_ready)
   );

endmodule

`default_nettype wire

//--- tb_write_path.sv
`timescale 1ns/1ns
`default_nettype none

module tb_write_path
   import cache_cfg_pkg::*, cache_bus_pkg::*;
();

   localparam logic [31:0] SEED = 32'h256d;
   localparam int N_RAND          = 200;
   localparam int N_HOT           = 120;
   localparam int DRAIN_CYCLES    = 500;
   localparam int TOTAL_REQS      = 4 + 6 + N_RAND + N_RAND + N_HOT;
   localparam int WATCHDOG_CYCLES = TOTAL_REQS * 40 + 4000;

   logic      clk;
   logic      reset;
   logic      valid;
   fe_write_t fe_req;
   logic      ready;
   logic      mem_valid;
   be_write_t mem_req;
   logic      mem_ready;

   logic [31:0] rng_state = SEED;
   logic [31:0] rdy_state = SEED ^ 32'h9e37_79b9; // Own stream for the responder.
   int          ready_pct = 0;
   int          errors = 0;
   int          errs_at_start = 0;
   int          stall_cycles = 0;
   int          checked = 0;
   int          test_num = 0;
   int          tests_failed = 0;

   be_write_t exp_q [$];
   logic [7:0] shadow_exp [int unsigned];
   logic [7:0] shadow_obs [int unsigned];

   write_path_top write_path_top_i (
      .clk       (clk),
      .reset     (reset),
      .valid     (valid),
      .fe_req    (fe_req),
      .ready     (ready),
      .mem_valid (mem_valid),
      .mem_req   (mem_req),
      .mem_ready (mem_ready)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] draw();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // Word lands at lane*4 bytes of a 16-byte aligned line.
   function automatic be_write_t expected_write(input fe_write_t r);
      be_write_t   e;
      int unsigned lane;
      int unsigned pos;
      lane    = r.addr[WORD_SEL_W-1:0];
      e.addr  = (32'(r.addr) << FE_BYTE_W) & ~32'(BE_NBYTES - 1);
      e.wstrb = '0;
      e.wdata = '0;
      for (int b = 0; b < FE_NBYTES; b++)
      begin
         pos = lane * FE_NBYTES + b;
         e.wstrb[pos]         = r.wstrb[b];
         e.wdata[pos*8 +: 8] = r.wdata[b*8 +: 8];
      end
      return e;
   endfunction

   function automatic void shadow_write(input bit observed, input be_write_t w);
      int unsigned a;
      for (int b = 0; b < BE_NBYTES; b++)
      begin
         if (w.wstrb[b])
         begin
            a = w.addr + b;
            if (observed)
            begin
               shadow_obs[a] = w.wdata[b*8 +: 8];
            end
            else
            begin
               shadow_exp[a] = w.wdata[b*8 +: 8];
            end
         end
      end
   endfunction

   function automatic int shadow_diffs();
      int diffs;
      diffs = (shadow_exp.num() != shadow_obs.num()) ? 1 : 0;
      foreach (shadow_exp[a])
      begin
         if (!shadow_obs.exists(a) || shadow_obs[a] !== shadow_exp[a])
         begin
            diffs++;
         end
      end
      return diffs;
   endfunction

   function automatic logic [3:0] strobe_pattern(input int i);
      case (i)
         0: return 4'b0001;
         1: return 4'b0110;
         2: return 4'b1000;
         3: return 4'b0000;
         4: return 4'b1010;
         default: return 4'b0101;
      endcase
   endfunction

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #4 clk = ~clk;
      end
   end

   // Memory responder.
   always @(posedge clk)
   begin
      rdy_state = xorshift(rdy_state);
      mem_ready <= (rdy_state % 100) < ready_pct;
   end

   // Acceptance monitor and compare process sample mid-cycle.
   always @(negedge clk)
   begin
      be_write_t want;
      int        idx;
      if (!reset)
      begin
         if (valid && ready)
         begin
            exp_q.push_back(expected_write(fe_req));
            shadow_write(1'b0, expected_write(fe_req)); // Program order gives last writer wins.
         end
         if (valid && !ready)
         begin
            stall_cycles++;
         end
         if (mem_valid && mem_ready)
         begin
            idx = -1;
            for (int i = 0; i < exp_q.size(); i++)
            begin
               if (idx < 0 &&
                   exp_q[i].addr[BE_BYTE_W +: BANK_W] == mem_req.addr[BE_BYTE_W +: BANK_W])
               begin
                  idx = i; // Oldest pending write of this bank.
               end
            end
            assert (idx >= 0)
            else
            begin
               errors++;
               $display("Error at %0t: write to %h completed but bank %0d has no pending write",
                        $time, mem_req.addr, mem_req.addr[BE_BYTE_W +: BANK_W]);
            end
            if (idx >= 0)
            begin
               want = exp_q[idx];
               exp_q.delete(idx);
               checked++;
               assert (mem_req === want)
               else
               begin
                  errors++;
                  $display("Mismatch at %0t: got addr %h strb %h data %h, expected %h %h %h",
                           $time, mem_req.addr, mem_req.wstrb, mem_req.wdata,
                           want.addr, want.wstrb, want.wdata);
               end
            end
            shadow_write(1'b1, mem_req);
         end
      end
   end

   task automatic begin_test(input int pct);
      @(negedge clk);
      ready_pct     = pct;
      errs_at_start = errors;
      stall_cycles  = 0;
      shadow_exp.delete();
      shadow_obs.delete();
      @(posedge clk);
   endtask

   // Call at a rising edge; returns on the edge that accepts the write.
   task automatic send_write(input fe_write_t r);
      valid  <= 1'b1;
      fe_req <= r;
      @(negedge clk);
      while (!ready)
      begin
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic end_test(input string name, input int n);
      int errs;
      int diffs;
      valid <= 1'b0;
      for (int i = 0; i < DRAIN_CYCLES && exp_q.size() != 0; i++)
      begin
         @(posedge clk);
      end
      repeat (8) @(posedge clk); // Late duplicates would land here.
      assert (exp_q.size() == 0)
      else
      begin
         errors++;
         $display("Error at %0t: %0d writes never reached memory", $time, exp_q.size());
      end
      exp_q.delete();
      diffs = shadow_diffs();
      assert (diffs == 0)
      else
      begin
         errors++;
         $display("Mismatch at %0t: shadow memory differs in %0d bytes", $time, diffs);
      end
      errs = errors - errs_at_start;
      test_num++;
      if (errs != 0)
      begin
         tests_failed++;
      end
      $display("test %0d %s: %s, %0d writes, %0d errors", test_num, name,
               (errs == 0) ? "pass" : "fail", n, errs);
   endtask

   task automatic run_random(input int n, input int max_gap, input bit hot);
      fe_write_t r;
      int        gap;
      for (int i = 0; i < n; i++)
      begin
         r.wstrb = draw();
         r.wdata = draw();
         if (hot && (draw() % 4) != 0)
         begin
            r.addr = {24'h000040, 2'(draw()), 2'b10, 2'(draw())}; // Bank 2 across four lines.
         end
         else
         begin
            r.addr = 30'h1000 | 30'(draw() & 32'h3ff);
         end
         send_write(r);
         gap = (max_gap > 0) ? (draw() % (max_gap + 1)) : 0;
         if (gap != 0)
         begin
            valid <= 1'b0;
            repeat (gap) @(posedge clk);
         end
      end
   endtask

   initial
   begin
      fe_write_t r;
      reset     = 1'b1;
      valid     = 1'b0;
      fe_req    = '0;
      mem_ready = 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      begin_test(0);
      @(negedge clk);
      assert (ready === 1'b1 && mem_valid === 1'b0 && mem_req.wstrb === '0)
      else
      begin
         errors++;
         $display("Mismatch at %0t: after reset got ready %b mem_valid %b wstrb %h",
                  $time, ready, mem_valid, mem_req.wstrb);
      end
      @(posedge clk);
      end_test("reset state", 0);

      begin_test(100);
      for (int k = 0; k < 4; k++)
      begin
         r.addr  = 30'h100 | 30'(k << 2) | 30'(k);
         r.wstrb = 4'hf;
         r.wdata = 32'ha0b0_c0d0 + k;
         send_write(r);
      end
      end_test("lane placement", 4);

      begin_test(100);
      for (int k = 0; k < 6; k++)
      begin
         r.addr  = 30'h200 | 30'(((k + 1) % 4) << 2) | 30'(k % 4);
         r.wstrb = strobe_pattern(k);
         r.wdata = draw();
         send_write(r);
      end
      end_test("strobe patterns", 6);

      begin_test(100);
      run_random(N_RAND, 2, 1'b0);
      end_test("random, no stall", N_RAND);

      begin_test(30);
      run_random(N_RAND, 1, 1'b0);
      assert (stall_cycles > 0)
      else
      begin
         errors++;
         $display("Error at %0t: ready never dropped under back-pressure", $time);
      end
      end_test("random, back-pressure", N_RAND);

      begin_test(50);
      run_random(N_HOT, 0, 1'b1);
      end_test("hot bank", N_HOT);

      $display("%0d tests, %0d failed, %0d writes checked, %0d errors",
               test_num, tests_failed, checked, errors);
      if (errors == 0)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
cache_cfg_pkg.sv
cache_bus_pkg.sv
bank_write_router.sv
write_channel_native.sv
be_write_arbiter.sv
write_path_top.sv
tb_write_path.sv

//--- Bender.yml
package:
  name: write_path

sources:
  - cache_cfg_pkg.sv
  - cache_bus_pkg.sv
  - bank_write_router.sv
  - write_channel_native.sv
  - be_write_arbiter.sv
  - write_path_top.sv
  - target: test
    files:
      - tb_write_path.sv
